// ==== tcb_pkg.sv ====
// shared widths and types, 32-bit data with byte lanes and a 16-bit byte address
// the select field is read as a byte-enable mask or as a size, never both at once
package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // data bus
  localparam int unsigned DAT_W = 32;
  // byte lanes
  localparam int unsigned BEN_W = DAT_W / 8;
  // byte address
  localparam int unsigned ADR_W = 16;
  // byte offset inside one word
  localparam int unsigned OFF_W = $clog2(BEN_W);

  //////////////////////////////////////////////////////////////////////
  // request encodings
  //////////////////////////////////////////////////////////////////////

  // memory mode uses ben, reference mode uses siz
  typedef enum logic {
    TCB_MEMORY    = 1'b0,
    TCB_REFERENCE = 1'b1
  } tcb_mode_t;

  // reference view, siz is log2 of the byte count
  typedef struct packed {
    logic [BEN_W-3:0] pad;
    logic [1:0]       siz;
  } tcb_ref_sel_t;

  // one select word, two decodings
  typedef union packed {
    logic [BEN_W-1:0] ben;
    tcb_ref_sel_t     ref_sel;
  } tcb_sel_u;

  //////////////////////////////////////////////////////////////////////
  // transfers
  //////////////////////////////////////////////////////////////////////

  // client side request
  typedef struct packed {
    logic             wen;
    tcb_mode_t        mode;
    logic [ADR_W-1:0] adr;
    tcb_sel_u         sel;
    logic [DAT_W-1:0] wdt;
  } tcb_req_t;

  // memory side, word aligned address and lane aligned data
  typedef struct packed {
    logic             wen;
    logic [ADR_W-1:0] adr;
    logic [BEN_W-1:0] ben;
    logic [DAT_W-1:0] wdt;
  } tcb_mem_req_t;

  // response, sts always clear
  typedef struct packed {
    logic [DAT_W-1:0] rdt;
    logic             sts;
  } tcb_rsp_t;

endpackage

// ==== tcb_req_gate.sv ====
// credit gate, req_rdy is high while credits remain
// credits come back only through crd pulses from the response buffer
`timescale 1ns/1ps

module tcb_req_gate #(
  parameter int unsigned DEPTH = 4
)(
  input  logic              tcb,
  input  logic              reset,
  input  logic              req_vld,
  input  tcb_pkg::tcb_req_t req,
  input  logic              crd,
  output logic              req_rdy,
  output logic              trn,
  output tcb_pkg::tcb_req_t trn_req
);

  // counter holds 0..DEPTH
  localparam int unsigned CW = $clog2(DEPTH + 1);

  logic [CW-1:0] cnt;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // ready while at least one credit is left
  assign req_rdy = (cnt != '0);

  // transfer on valid and ready
  assign trn = req_vld & req_rdy;

  // accepted request goes on unchanged
  assign trn_req = req;

  //////////////////////////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////////////////////////

  // spend on accept, refund on crd, both may coincide
  always_ff @(posedge tcb) begin
    if (reset) begin
      cnt <= CW'(DEPTH);
    end else begin
      case ({trn, crd})
        2'b10:   cnt <= cnt - 1'b1;
        2'b01:   cnt <= cnt + 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // count stays within the initial credit
  assert property (@(posedge tcb) disable iff (reset) cnt <= CW'(DEPTH))
    else $error("credit count above DEPTH: %0d", cnt);

  // buffer never refunds a credit that was not spent
  assert property (@(posedge tcb) disable iff (reset)
    (crd && !trn) |-> (cnt < CW'(DEPTH)))
    else $error("stray credit with full count");

endmodule

// ==== tcb_ref2mem.sv ====
// reference to memory mode converter, fixed read latency DLY of at least 1
// reference transfers must stay inside one word
`timescale 1ns/1ps

module tcb_ref2mem #(
  parameter int unsigned DLY = 2
)(
  input  logic                  tcb,
  input  logic                  reset,
  input  logic                  trn,
  input  tcb_pkg::tcb_req_t     req,
  input  tcb_pkg::tcb_rsp_t     mem_rsp,
  input  logic                  mem_rsp_trn,
  output logic                  mem_trn,
  output tcb_pkg::tcb_mem_req_t mem_req,
  output tcb_pkg::tcb_rsp_t     rsp,
  output logic                  rsp_trn
);

  import tcb_pkg::*;

  // per request return info
  typedef struct packed {
    tcb_mode_t        mode;
    logic [OFF_W-1:0] off;
  } tag_t;

  logic [OFF_W-1:0] off;
  logic [BEN_W-1:0] siz_msk;
  tag_t             tag_q [DLY];
  logic [DLY-1:0]   vld_q;
  tag_t             ret;

  // byte rotation toward higher lanes
  function automatic logic [DAT_W-1:0] rot_up(input logic [DAT_W-1:0] d,
                                              input logic [OFF_W-1:0] o);
    return (d << (8 * o)) | (d >> (DAT_W - 8 * o));
  endfunction

  // byte rotation toward lane 0
  function automatic logic [DAT_W-1:0] rot_down(input logic [DAT_W-1:0] d,
                                                input logic [OFF_W-1:0] o);
    return (d >> (8 * o)) | (d << (DAT_W - 8 * o));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////////////////////////

  assign off = req.adr[OFF_W-1:0];

  // size to a mask of the low lanes
  always_comb begin
    siz_msk = '0;
    for (int b = 0; b < BEN_W; b++) begin
      if (b < (1 << req.sel.ref_sel.siz)) siz_msk[b] = 1'b1;
    end
  end

  assign mem_trn = trn;

  always_comb begin
    mem_req.wen = req.wen;
    if (req.mode == TCB_REFERENCE) begin
      // aligned word, lanes at the byte offset
      mem_req.adr = {req.adr[ADR_W-1:OFF_W], {OFF_W{1'b0}}};
      mem_req.ben = siz_msk << off;
      mem_req.wdt = rot_up(req.wdt, off);
    end else begin
      mem_req.adr = req.adr;
      mem_req.ben = req.sel.ben;
      mem_req.wdt = req.wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // return path
  //////////////////////////////////////////////////////////////////////

  // tag travels beside the memory pipeline
  always_ff @(posedge tcb) begin
    tag_q[0] <= '{mode: req.mode, off: off};
    for (int d = 1; d < DLY; d++) begin
      tag_q[d] <= tag_q[d-1];
    end
  end

  always_ff @(posedge tcb) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= trn;
      for (int d = 1; d < DLY; d++) begin
        vld_q[d] <= vld_q[d-1];
      end
    end
  end

  assign ret     = tag_q[DLY-1];
  assign rsp_trn = mem_rsp_trn;

  // read data back to the low bytes
  always_comb begin
    rsp.sts = mem_rsp.sts;
    rsp.rdt = (ret.mode == TCB_REFERENCE) ? rot_down(mem_rsp.rdt, ret.off) : mem_rsp.rdt;
  end

  // reference transfer fits in one word
  assert property (@(posedge tcb) disable iff (reset)
    (trn && req.mode == TCB_REFERENCE) |->
      (int'(off) + (1 << req.sel.ref_sel.siz) <= BEN_W))
    else $error("reference transfer crosses word: adr=%h", req.adr);

  // memory mode address is aligned
  assert property (@(posedge tcb) disable iff (reset)
    (trn && req.mode == TCB_MEMORY) |-> (off == '0))
    else $error("unaligned memory mode address: adr=%h", req.adr);

  // memory returns in step with the local tag pipe
  assert property (@(posedge tcb) disable iff (reset) mem_rsp_trn == vld_q[DLY-1])
    else $error("memory response out of step with tag pipeline");

endmodule

// ==== tcb_memory.sv ====
// shared byte array with SPN always-ready ports and a fixed read latency of DLY
// SIZ must be a multiple of the lane count, disabled lanes read back as zero
`timescale 1ns/1ps

module tcb_memory #(
  parameter int unsigned SPN = 2,
  parameter int unsigned SIZ = 256,
  parameter int unsigned DLY = 2
)(
  input  logic                  tcb,
  input  logic                  reset,
  input  logic [SPN-1:0]        trn,
  input  tcb_pkg::tcb_mem_req_t req [SPN],
  output tcb_pkg::tcb_rsp_t     rsp [SPN],
  output logic [SPN-1:0]        rsp_trn
);

  import tcb_pkg::*;

  // array index width
  localparam int unsigned AW = $clog2(SIZ);

  logic [7:0]    mem  [SIZ];
  logic [AW-1:0] base [SPN];

  //////////////////////////////////////////////////////////////////////
  // addressing
  //////////////////////////////////////////////////////////////////////

  // word base, wraps modulo SIZ
  for (genvar i = 0; i < SPN; i++) begin : g_base
    assign base[i] = AW'(req[i].adr % SIZ);
  end

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  // later ports overwrite earlier ones in the same cycle
  always_ff @(posedge tcb) begin
    for (int i = 0; i < SPN; i++) begin
      if (trn[i] && req[i].wen) begin
        for (int b = 0; b < BEN_W; b++) begin
          if (req[i].ben[b]) mem[int'(base[i]) + b] <= req[i].wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read pipeline per port
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < SPN; i++) begin : g_port

    // stage 0, combinational
    logic [BEN_W-1:0][7:0]            rd0;
    logic [BEN_W-1:0]                 bn0;
    // registered stages
    logic [DLY-1:0]                   vld_q;
    logic [DLY-1:0][BEN_W-1:0]        ben_q;
    logic [DLY-1:0][BEN_W-1:0][7:0]   rdt_q;
    logic [DAT_W-1:0]                 rdt;

    always_comb begin
      for (int b = 0; b < BEN_W; b++) begin
        rd0[b] = mem[int'(base[i]) + b];
      end
    end

    // writes carry no lanes down the pipe
    assign bn0 = (trn[i] && !req[i].wen) ? req[i].ben : '0;

    // one valid per accepted request, read or write
    always_ff @(posedge tcb) begin
      if (reset) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= trn[i];
        for (int d = 1; d < DLY; d++) begin
          vld_q[d] <= vld_q[d-1];
        end
      end
    end

    // data moves only in the lanes its request enabled
    always_ff @(posedge tcb) begin
      ben_q[0] <= bn0;
      for (int b = 0; b < BEN_W; b++) begin
        if (bn0[b]) rdt_q[0][b] <= rd0[b];
      end
      for (int d = 1; d < DLY; d++) begin
        ben_q[d] <= ben_q[d-1];
        for (int b = 0; b < BEN_W; b++) begin
          if (ben_q[d-1][b]) rdt_q[d][b] <= rdt_q[d-1][b];
        end
      end
    end

    // last stage, unused lanes as zero
    always_comb begin
      for (int b = 0; b < BEN_W; b++) begin
        rdt[8*b +: 8] = ben_q[DLY-1][b] ? rdt_q[DLY-1][b] : 8'h00;
      end
    end

    // no error sources
    assign rsp[i]     = '{rdt: rdt, sts: 1'b0};
    assign rsp_trn[i] = vld_q[DLY-1];

  end : g_port

  // word wrap and a real pipeline need these
  assert property (@(posedge tcb) (SIZ % BEN_W == 0) && (DLY >= 1))
    else $error("bad memory parameters: SIZ=%0d DLY=%0d", SIZ, DLY);

endmodule

// ==== tcb_rsp_buffer.sv ====
// response FIFO of DEPTH entries, one crd pulse per pop
// never pushed while full, the credit loop in front guarantees that
`timescale 1ns/1ps

module tcb_rsp_buffer #(
  parameter int unsigned DEPTH = 4
)(
  input  logic              tcb,
  input  logic              reset,
  input  logic              push,
  input  tcb_pkg::tcb_rsp_t push_rsp,
  input  logic              rsp_rdy,
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp,
  output logic              crd
);

  import tcb_pkg::*;

  // pointer and fill count widths
  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  tcb_rsp_t      buf_mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          pop;

  // circular increment
  function automatic logic [PW-1:0] nxt(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (push) buf_mem[wr_ptr] <= push_rsp;
  end

  // head entry
  assign rsp     = buf_mem[rd_ptr];
  assign rsp_vld = (cnt != '0);
  assign pop     = rsp_vld & rsp_rdy;
  // freed slot goes back as a credit
  assign crd     = pop;

  //////////////////////////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= nxt(wr_ptr);
      if (pop)  rd_ptr <= nxt(rd_ptr);
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // credits keep the FIFO from overflowing
  assert property (@(posedge tcb) disable iff (reset) push |-> (cnt < CW'(DEPTH)))
    else $error("push into full response buffer, cnt=%0d", cnt);

endmodule

// ==== tcb_subsystem.sv ====
// SPN client ports on one shared memory, reads return DLY cycles after accept
// each port holds at most DEPTH requests in flight or buffered
`timescale 1ns/1ps

module tcb_subsystem #(
  parameter int unsigned SPN   = 2,
  parameter int unsigned SIZ   = 256,
  parameter int unsigned DLY   = 2,
  parameter int unsigned DEPTH = 4
)(
  input  logic              tcb,
  input  logic              reset,
  input  logic [SPN-1:0]    req_vld,
  input  tcb_pkg::tcb_req_t req [SPN],
  input  logic [SPN-1:0]    rsp_rdy,
  output logic [SPN-1:0]    req_rdy,
  output logic [SPN-1:0]    rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp [SPN]
);

  import tcb_pkg::*;

  // gate to converter
  logic [SPN-1:0] gate_trn;
  tcb_req_t       gate_req [SPN];
  // converter to memory and back
  logic [SPN-1:0] mem_trn;
  tcb_mem_req_t   mem_req [SPN];
  logic [SPN-1:0] mem_rsp_trn;
  tcb_rsp_t       mem_rsp [SPN];
  // converter to buffer
  logic [SPN-1:0] cnv_trn;
  tcb_rsp_t       cnv_rsp [SPN];
  // buffer back to gate
  logic [SPN-1:0] crd;

  //////////////////////////////////////////////////////////////////////
  // per port client path
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < SPN; i++) begin : g_port

    tcb_req_gate #(.DEPTH(DEPTH)) gate_i (
      .tcb     (tcb),
      .reset   (reset),
      .req_vld (req_vld[i]),
      .req     (req[i]),
      .crd     (crd[i]),
      .req_rdy (req_rdy[i]),
      .trn     (gate_trn[i]),
      .trn_req (gate_req[i])
    );

    tcb_ref2mem #(.DLY(DLY)) ref2mem_i (
      .tcb         (tcb),
      .reset       (reset),
      .trn         (gate_trn[i]),
      .req         (gate_req[i]),
      .mem_rsp     (mem_rsp[i]),
      .mem_rsp_trn (mem_rsp_trn[i]),
      .mem_trn     (mem_trn[i]),
      .mem_req     (mem_req[i]),
      .rsp         (cnv_rsp[i]),
      .rsp_trn     (cnv_trn[i])
    );

    tcb_rsp_buffer #(.DEPTH(DEPTH)) buffer_i (
      .tcb      (tcb),
      .reset    (reset),
      .push     (cnv_trn[i]),
      .push_rsp (cnv_rsp[i]),
      .rsp_rdy  (rsp_rdy[i]),
      .rsp_vld  (rsp_vld[i]),
      .rsp      (rsp[i]),
      .crd      (crd[i])
    );

  end : g_port

  //////////////////////////////////////////////////////////////////////
  // shared array
  //////////////////////////////////////////////////////////////////////

  tcb_memory #(.SPN(SPN), .SIZ(SIZ), .DLY(DLY)) memory_i (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (mem_trn),
    .req     (mem_req),
    .rsp     (mem_rsp),
    .rsp_trn (mem_rsp_trn)
  );

endmodule

// ==== tcb_subsystem_tb.sv ====
// testbench for tcb_subsystem with 2 ports, 256 bytes, DLY 2 and DEPTH 4
// the array is filled before any read, so unwritten bytes are never compared
`timescale 1ns/1ps

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int unsigned SPN   = 2;
  localparam int unsigned SIZ   = 256;
  localparam int unsigned DLY   = 2;
  localparam int unsigned DEPTH = 4;

  // cycle budget per test and a watchdog of twice the sum at 4 ns
  localparam int T_CYC       = 20 + 200 + 200 + 50 + 60 + 80 + 40;
  localparam int WATCHDOG_NS = T_CYC * 4 * 2;

  // expected read data and the bits of its enabled lanes
  typedef struct packed {
    logic [DAT_W-1:0] rdt;
    logic [DAT_W-1:0] bits;
  } exp_t;

  logic             tcb = 1'b0;
  logic             reset;
  logic [SPN-1:0]   req_vld;
  tcb_req_t         req [SPN];
  logic [SPN-1:0]   rsp_rdy;
  logic [SPN-1:0]   req_rdy;
  logic [SPN-1:0]   rsp_vld;
  tcb_rsp_t         rsp [SPN];

  // checker state
  logic [SPN-1:0]   acc;
  logic [SPN-1:0]   pop;
  logic [7:0]       shadow [SIZ];
  exp_t             exp_q [SPN][$];
  int               pend [SPN];
  logic [DAT_W-1:0] head_rdt [SPN];
  logic [DAT_W-1:0] head_bits [SPN];
  logic [DLY:0]     acc_sr [SPN];
  logic [DLY:0]     iso_sr [SPN];
  logic             rst_d = 1'b0;

  integer           seed;
  int               err_cnt = 0;
  int               err_at = 0;
  int               rsp_cnt = 0;
  int               test_cnt = 0;
  logic [ADR_W-1:0] adr;
  logic [BEN_W-1:0] ben;

  tcb_subsystem #(.SPN(SPN), .SIZ(SIZ), .DLY(DLY), .DEPTH(DEPTH)) tcb_subsystem_i (
    .tcb(tcb), .reset(reset), .req_vld(req_vld), .req(req), .rsp_rdy(rsp_rdy),
    .req_rdy(req_rdy), .rsp_vld(rsp_vld), .rsp(rsp)
  );

  always #2 tcb = ~tcb;

  assign acc = req_vld & req_rdy;
  assign pop = rsp_vld & rsp_rdy;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // fill value depends on the whole address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 37) ^ (a >> 3) ^ 8'ha5);
  endfunction

  function automatic tcb_req_t mk_req(input logic wen, input tcb_mode_t mode,
                                      input logic [ADR_W-1:0] a, input logic [3:0] sel,
                                      input logic [DAT_W-1:0] wdt);
    tcb_req_t r;
    r.wen     = wen;
    r.mode    = mode;
    r.adr     = a;
    r.sel.ben = sel;
    r.wdt     = wdt;
    return r;
  endfunction

  // reads see the array before this edge's writes
  // reference data sits in the low bytes, memory mode in the enabled lanes
  function automatic exp_t expect_rsp(input tcb_req_t r);
    exp_t e;
    int   base;
    e    = '0;
    base = int'(r.adr) % SIZ;
    if (r.wen) return e;
    for (int b = 0; b < BEN_W; b++) begin
      if (r.mode == TCB_MEMORY ? r.sel.ben[b] : (b < (1 << r.sel.ref_sel.siz))) begin
        e.rdt[8*b +: 8]  = shadow[(base + b) % SIZ];
        e.bits[8*b +: 8] = 8'hff;
      end
    end
    return e;
  endfunction

  function automatic void write_shadow(input tcb_req_t r);
    int base;
    base = int'(r.adr) % SIZ;
    for (int b = 0; b < BEN_W; b++) begin
      if (r.mode == TCB_MEMORY ? r.sel.ben[b] : (b < (1 << r.sel.ref_sel.siz))) begin
        shadow[(base + b) % SIZ] = r.wdt[8*b +: 8];
      end
    end
  endfunction

  // pops first, then expected data, then writes with port 1 last
  always @(posedge tcb) begin
    logic [SPN-1:0] iso;
    for (int p = 0; p < SPN; p++) begin
      iso[p] = acc[p] && (exp_q[p].size() == 0);
    end
    if (reset) begin
      for (int p = 0; p < SPN; p++) begin
        exp_q[p].delete();
        pend[p]   <= 0;
        acc_sr[p] <= '0;
        iso_sr[p] <= '0;
      end
    end else begin
      for (int p = 0; p < SPN; p++) begin
        if (pop[p] && exp_q[p].size() > 0) begin
          void'(exp_q[p].pop_front());
          rsp_cnt++;
        end
      end
      for (int p = 0; p < SPN; p++) begin
        if (acc[p]) exp_q[p].push_back(expect_rsp(req[p]));
      end
      for (int p = 0; p < SPN; p++) begin
        if (acc[p] && req[p].wen) write_shadow(req[p]);
      end
      for (int p = 0; p < SPN; p++) begin
        pend[p]      <= exp_q[p].size();
        head_rdt[p]  <= (exp_q[p].size() > 0) ? exp_q[p][0].rdt : '0;
        head_bits[p] <= (exp_q[p].size() > 0) ? exp_q[p][0].bits : '0;
        acc_sr[p]    <= {acc_sr[p][DLY-1:0], acc[p]};
        iso_sr[p]    <= {iso_sr[p][DLY-1:0], iso[p]};
      end
    end
    rst_d <= reset;
  end

  //////////////////////////////////////////////////////////////////////
  // assertions per port
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < SPN; p++) begin : g_chk
    // popped data compared in enabled lanes only
    assert property (@(posedge tcb) disable iff (reset)
      (pop[p] && pend[p] > 0) |-> ((rsp[p].rdt & head_bits[p]) == head_rdt[p]))
      else begin
        err_cnt++;
        $display("[FAIL] rsp[%0d].rdt got %h exp %h lanes %h", p,
                 $sampled(rsp[p].rdt), $sampled(head_rdt[p]), $sampled(head_bits[p]));
      end
    assert property (@(posedge tcb) disable iff (reset) pop[p] |-> (rsp[p].sts == 1'b0))
      else begin
        err_cnt++;
        $display("[FAIL] rsp[%0d].sts got %h exp 0", p, $sampled(rsp[p].sts));
      end
    assert property (@(posedge tcb) disable iff (reset) pop[p] |-> (pend[p] > 0))
      else begin
        err_cnt++;
        $display("port %0d returned a response with no request outstanding", p);
      end
    // ready exactly while fewer than DEPTH are outstanding
    assert property (@(posedge tcb) disable iff (reset) req_rdy[p] == (pend[p] < DEPTH))
      else begin
        err_cnt++;
        $display("[FAIL] req_rdy[%0d] got %h exp %h", p, $sampled(req_rdy[p]),
                 $sampled(pend[p]) < DEPTH);
      end
    assert property (@(posedge tcb) disable iff (reset) (pend[p] == 0) |-> !rsp_vld[p])
      else begin
        err_cnt++;
        $display("[FAIL] rsp_vld[%0d] got 1 exp 0", p);
      end
    // latency is never early when idle and never later than DLY
    assert property (@(posedge tcb) disable iff (reset) iso_sr[p][DLY-1] |-> !rsp_vld[p])
      else begin
        err_cnt++;
        $display("port %0d response arrived before DLY cycles", p);
      end
    assert property (@(posedge tcb) disable iff (reset) acc_sr[p][DLY] |-> rsp_vld[p])
      else begin
        err_cnt++;
        $display("port %0d response missing DLY cycles after accept", p);
      end
    // held reset state
    assert property (@(posedge tcb) (reset && rst_d) |-> (!rsp_vld[p] && req_rdy[p]))
      else begin
        err_cnt++;
        $display("[FAIL] port %0d in reset rsp_vld %h req_rdy %h exp 0 1", p,
                 $sampled(rsp_vld[p]), $sampled(req_rdy[p]));
      end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // called on a rising edge and returns on the edge of acceptance
  task automatic issue(input int p, input tcb_req_t r);
    req_vld[p] <= 1'b1;
    req[p]     <= r;
    do @(posedge tcb); while (!req_rdy[p]);
    req_vld[p] <= 1'b0;
  endtask

  task automatic issue_pair(input tcb_req_t r0, input tcb_req_t r1);
    req_vld <= '1;
    req[0]  <= r0;
    req[1]  <= r1;
    do @(posedge tcb); while (req_rdy != '1);
    req_vld <= '0;
  endtask

  // until every response is popped
  task automatic drain();
    @(posedge tcb);
    while (pend[0] != 0 || pend[1] != 0) @(posedge tcb);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_at);
    err_at = err_cnt;
  endtask

  initial begin
    seed    = 32'h8797bd47;
    reset   = 1'b1;
    req_vld = '0;
    rsp_rdy = '1;
    req[0]  = '0;
    req[1]  = '0;
    repeat (10) @(posedge tcb);
    reset <= 1'b0;

    // whole array filled, then random lanes written and read back
    for (int a = 0; a < SIZ; a += BEN_W) begin
      issue(0, mk_req(1, TCB_MEMORY, ADR_W'(a), 4'hf, {fill_byte(a + 3), fill_byte(a + 2),
                                                      fill_byte(a + 1), fill_byte(a)}));
    end
    for (int i = 0; i < 24; i++) begin
      adr = rnd() & 16'hfffc;
      ben = rnd();
      issue(0, mk_req(1, TCB_MEMORY, adr, ben, rnd()));
      issue(0, mk_req(0, TCB_MEMORY, adr, rnd(), '0));
    end
    drain();
    end_test("memory mode write and read");

    // every size at every legal offset, mixed with memory mode writes
    for (int rep = 0; rep < 4; rep++) begin
      for (int s = 0; s < 3; s++) begin
        for (int o = 0; o + (1 << s) <= BEN_W; o++) begin
          adr = (rnd() & 16'hfffc) | ADR_W'(o);
          issue(0, mk_req(1, TCB_REFERENCE, adr, 4'(s), rnd()));
          issue(0, mk_req(0, TCB_REFERENCE, adr, 4'(s), '0));
          issue(0, mk_req(1, TCB_MEMORY, adr & 16'hfffc, rnd(), rnd()));
          issue(0, mk_req(0, TCB_REFERENCE, adr, 4'(s), '0));
        end
      end
    end
    drain();
    end_test("reference mode transfers");

    // first read finds the port idle, the rest follow back to back
    for (int i = 0; i < 8; i++) begin
      issue(0, mk_req(0, TCB_MEMORY, rnd() & 16'hfffc, 4'hf, '0));
    end
    drain();
    end_test("read latency and pipelining");

    // buffer fills, credits run out, one request waits
    rsp_rdy[0] <= 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      issue(0, mk_req(0, TCB_MEMORY, rnd() & 16'hfffc, 4'hf, '0));
    end
    req_vld[0] <= 1'b1;
    req[0]     <= mk_req(0, TCB_REFERENCE, 16'h0013, 4'd0, '0);
    repeat (2 * DLY + 4) @(posedge tcb);
    rsp_rdy[0] <= 1'b1;
    do @(posedge tcb); while (!req_rdy[0]);
    req_vld[0] <= 1'b0;
    drain();
    end_test("back-pressure and credits");

    // same bytes from both ports, port 1 through a wrapped address
    for (int i = 0; i < 6; i++) begin
      adr = rnd() & 16'h00fc;
      issue_pair(mk_req(1, TCB_MEMORY, adr, 4'hf, rnd()),
                 mk_req(1, TCB_MEMORY, adr + 16'h0100 * ADR_W'(i + 1), 4'hf, rnd()));
      issue_pair(mk_req(0, TCB_MEMORY, adr | 16'h4000, 4'hf, '0),
                 mk_req(0, TCB_MEMORY, adr, 4'hf, '0));
      // byte 3 of the word written by both
      issue_pair(mk_req(1, TCB_REFERENCE, adr | 16'h0002, 4'd1, rnd()),
                 mk_req(1, TCB_REFERENCE, adr | 16'h0203, 4'd0, rnd()));
      issue_pair(mk_req(0, TCB_REFERENCE, adr, 4'd2, '0),
                 mk_req(0, TCB_REFERENCE, adr | 16'h8003, 4'd0, '0));
      drain();
    end
    end_test("two ports");

    // second reset with the ports idle
    reset <= 1'b1;
    repeat (10) @(posedge tcb);
    reset <= 1'b0;
    repeat (4) @(posedge tcb);
    issue(1, mk_req(0, TCB_MEMORY, 16'h0040, 4'hf, '0));
    drain();
    end_test("reset state");

    $display("tests %0d, responses checked %0d, errors %0d", test_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
tcb_pkg.sv
tcb_req_gate.sv
tcb_ref2mem.sv
tcb_memory.sv
tcb_rsp_buffer.sv
tcb_subsystem.sv
tcb_subsystem_tb.sv

// ==== Makefile ====
# Verilator flow for the TCB memory subsystem
TOOL    := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := tcb_subsystem_tb
FLIST   := all.f
OBJ_DIR := obj_dir
LOG     := sim.log
SRCS    := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
